//--- Makefile
# Verilator build and run of the Sachen 8259 mapper testbench.

VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_map_sachen8259
FILELIST   := map_sachen8259.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result; a crash without output also fails.
run: build
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure."; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status."; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- map_sachen8259.f
src/cart_bus_pkg.sv
src/sachen_map_pkg.sv
src/sachen_cpu_side.sv
src/sachen_ppu_map.sv
src/map_sachen8259.sv
tb/tb_map_sachen8259.sv

//--- src/cart_bus_pkg.sv
`default_nettype none

package cart_bus_pkg;

	// CPU bus as seen on the cartridge edge.
	localparam int CPU_ADDR_W = 16;

	// PPU bus, 16 KB of address space.
	localparam int PPU_ADDR_W = 14;

	// PRG ROM, eight 32 KB banks.
	localparam int PRG_ADDR_W = 18;

	// CHR memory, up to 512 KB.
	localparam int CHR_ADDR_W = 19;

	// Bank number above the 1 KB window offset.
	localparam int CHR_BANK_W = 9;

	// Address bits 14..8 of the index/data pair.
	// The pair sits at 0x4100 and mirrors through the page.
	localparam logic [6:0] REG_PAGE = 7'h41;

endpackage

`default_nettype wire

//--- src/map_sachen8259.sv
`default_nettype none

module map_sachen8259
	import cart_bus_pkg::*, sachen_map_pkg::*;
(
	input  wire                    m2,
	input  wire                    map_rst,

	input  wire [CPU_ADDR_W-1:0]   cpu_addr,
	input  wire [7:0]              cpu_dat,
	input  wire                    cpu_rw,
	input  wire                    cpu_ce,

	input  wire [7:0]              map_idx,
	input  wire                    cfg_chr_ram,

	input  wire [PPU_ADDR_W-1:0]   ppu_addr,
	input  wire                    ppu_oe,
	input  wire                    ppu_we,

	input  wire                    ss_act,
	input  wire                    ss_we,
	input  wire [7:0]              ss_addr,

	output logic [PRG_ADDR_W-1:0]  prg_addr,
	output logic                   prg_oe,
	output logic                   rom_ce,

	output logic [CHR_ADDR_W-1:0]  chr_addr,
	output logic                   chr_oe,
	output logic                   chr_we,
	output logic                   chr_ce,

	output logic                   ciram_a10,
	output logic                   ciram_ce,

	output logic [7:0]             ss_rdat
);

	// Register file, from the CPU side to the PPU side.
	wire bank_regs_t regs;

	sachen_cpu_side sachen_cpu_side_i (
		.m2       (m2),
		.map_rst  (map_rst),
		.cpu_addr (cpu_addr),
		.cpu_dat  (cpu_dat),
		.cpu_rw   (cpu_rw),
		.cpu_ce   (cpu_ce),
		.map_idx  (map_idx),
		.ss_act   (ss_act),
		.ss_we    (ss_we),
		.ss_addr  (ss_addr),
		.ss_rdat  (ss_rdat),
		.regs     (regs),
		.prg_addr (prg_addr),
		.prg_oe   (prg_oe),
		.rom_ce   (rom_ce)
	);

	sachen_ppu_map sachen_ppu_map_i (
		.regs        (regs),
		.map_idx     (map_idx),
		.cfg_chr_ram (cfg_chr_ram),
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.chr_addr    (chr_addr),
		.chr_oe      (chr_oe),
		.chr_we      (chr_we),
		.chr_ce      (chr_ce),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce)
	);

endmodule

`default_nettype wire

//--- src/sachen_cpu_side.sv
`default_nettype none

module sachen_cpu_side
	import cart_bus_pkg::*, sachen_map_pkg::*;
(
	input  wire                    m2,
	input  wire                    map_rst,

	// CPU bus.
	input  wire [CPU_ADDR_W-1:0]   cpu_addr,
	input  wire [7:0]              cpu_dat,
	input  wire                    cpu_rw,
	input  wire                    cpu_ce,

	input  wire [7:0]              map_idx,

	// Save-state port.
	input  wire                    ss_act,
	input  wire                    ss_we,
	input  wire [7:0]              ss_addr,
	output logic [7:0]             ss_rdat,

	output bank_regs_t             regs,

	// PRG ROM.
	output logic [PRG_ADDR_W-1:0]  prg_addr,
	output logic                   prg_oe,
	output logic                   rom_ce
);

	// Index register of the index/data pair.
	logic [REG_SEL_W-1:0] reg_addr;

	logic reg_page_hit;
	logic reg_we;
	logic ss_reg_hit;

	// Index at even addresses, data at odd ones.
	assign reg_page_hit = cpu_addr[14:8] == REG_PAGE;
	assign reg_we = cpu_ce && !cpu_rw && reg_page_hit;

	assign ss_reg_hit = ss_addr < 8'(REG_COUNT);

	// Registers change on the falling edge of m2.
	// The data bus is stable there for a CPU write.
	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			reg_addr <= '0;
			regs <= '0;
		end
		else if (ss_act)
		begin
			// State restore takes the bus, so CPU writes are dropped.
			if (ss_we && ss_reg_hit)
				regs[ss_addr[REG_SEL_W-1:0]] <= cpu_dat[REG_W-1:0];
			if (ss_we && ss_addr == SS_REG_ADDR)
				reg_addr <= cpu_dat[REG_SEL_W-1:0];
		end
		else if (reg_we)
		begin
			if (!cpu_addr[0])
				reg_addr <= cpu_dat[REG_SEL_W-1:0];
			else
				regs[reg_addr] <= cpu_dat[REG_W-1:0];
		end
	end

	// Save-state readback.
	always_comb
	begin
		if (ss_reg_hit)
			ss_rdat = 8'(regs[ss_addr[REG_SEL_W-1:0]]);
		else if (ss_addr == SS_REG_ADDR)
			ss_rdat = 8'(reg_addr);
		else if (ss_addr == SS_IDX_ADDR)
			ss_rdat = map_idx;
		else
			ss_rdat = 8'hFF;
	end

	// One 32 KB bank over the whole 0x8000-0xFFFF window.
	assign prg_addr = {regs[REG_PRG], cpu_addr[PRG_ADDR_W-REG_W-1:0]};

	assign prg_oe = cpu_rw;

	// cpu_ce marks the register window; ROM answers everywhere else.
	assign rom_ce = !cpu_ce;

endmodule

`default_nettype wire

//--- src/sachen_map_pkg.sv
`default_nettype none

package sachen_map_pkg;

	// Bank register file.
	localparam int REG_W = 3;
	localparam int REG_COUNT = 8;

	// Width of the index that picks one register.
	localparam int REG_SEL_W = $clog2(REG_COUNT);

	// Supported board variants.
	localparam logic [7:0] MAP_137 = 8'd137;
	localparam logic [7:0] MAP_138 = 8'd138;
	localparam logic [7:0] MAP_139 = 8'd139;
	localparam logic [7:0] MAP_141 = 8'd141;

	// Registers 0 to 3 are the CHR banks proper.
	// High CHR bits shared by all four slots.
	localparam int REG_HIGH = 4;
	// 32 KB PRG bank.
	localparam int REG_PRG = 5;
	// Extra CHR bit, used by 137 only.
	localparam int REG_EXT = 6;
	// Bit 0 simple mode, bits 2..1 mirroring.
	localparam int REG_MODE = 7;

	// Save-state map.
	// Addresses 0 to 7 hold the bank registers.
	localparam logic [7:0] SS_REG_ADDR = 8'd8;
	localparam logic [7:0] SS_IDX_ADDR = 8'd127;

	// Whole register file as one packed value.
	typedef logic [REG_COUNT-1:0][REG_W-1:0] bank_regs_t;

endpackage

`default_nettype wire

//--- src/sachen_ppu_map.sv
`default_nettype none

module sachen_ppu_map
	import cart_bus_pkg::*, sachen_map_pkg::*;
(
	input  wire bank_regs_t        regs,
	input  wire [7:0]              map_idx,
	input  wire                    cfg_chr_ram,

	// PPU bus, strobes active low.
	input  wire [PPU_ADDR_W-1:0]   ppu_addr,
	input  wire                    ppu_oe,
	input  wire                    ppu_we,

	// CHR memory.
	output logic [CHR_ADDR_W-1:0]  chr_addr,
	output logic                   chr_oe,
	output logic                   chr_we,
	output logic                   chr_ce,

	// Console nametable RAM.
	output logic                   ciram_a10,
	output logic                   ciram_ce
);

	// 1 KB slot within a pattern table.
	logic [1:0] slot;

	// Bits 4..3 of the 137 bank.
	logic [1:0] hi_137;

	// Register picked for the 2 KB / 4 KB variants.
	logic [REG_W-1:0] sel;

	logic simple_mode;

	logic [CHR_BANK_W-1:0] bank_137;
	logic [CHR_BANK_W-1:0] bank_138;
	logic [CHR_BANK_W-1:0] bank_139;
	logic [CHR_BANK_W-1:0] bank_141;
	logic [CHR_BANK_W-1:0] bank;

	assign slot = ppu_addr[11:10];
	assign simple_mode = regs[REG_MODE][0];

	// Mapper 137, four 1 KB banks in the lower table.
	always_comb
	begin
		case (slot)
			2'd0: hi_137 = 2'b00;
			2'd1: hi_137 = {1'b0, regs[REG_HIGH][0]};
			2'd2: hi_137 = {1'b0, regs[REG_HIGH][1]};
			default: hi_137 = {regs[REG_EXT][0], regs[REG_HIGH][2]};
		endcase
	end

	// Upper table is fixed to the last 4 KB.
	assign bank_137 = ppu_addr[12] ? CHR_BANK_W'({3'b111, slot}) :
		CHR_BANK_W'({hi_137, regs[slot]});

	// Simple mode repeats register 0 over all four quarters.
	assign sel = simple_mode ? regs[0] : regs[ppu_addr[12:11]];

	// The three others differ only in page size.
	// 138 uses 2 KB pages.
	assign bank_138 = CHR_BANK_W'({regs[REG_HIGH], sel, ppu_addr[10]});
	// 139 uses 8 KB.
	assign bank_139 = CHR_BANK_W'({regs[REG_HIGH], sel, ppu_addr[12:10]});
	// 141 uses 4 KB.
	assign bank_141 = CHR_BANK_W'({regs[REG_HIGH], sel, ppu_addr[11:10]});

	always_comb
	begin
		if (cfg_chr_ram)
			bank = CHR_BANK_W'(ppu_addr[12:10]);
		else
		begin
			case (map_idx)
				MAP_137: bank = bank_137;
				MAP_138: bank = bank_138;
				MAP_139: bank = bank_139;
				MAP_141: bank = bank_141;
				// Unknown numbers fall back to 141 wiring.
				default: bank = bank_141;
			endcase
		end
	end

	assign chr_addr = {bank, ppu_addr[9:0]};

	// Nametable mirroring from bits 2..1 of the mode register.
	always_comb
	begin
		if (simple_mode)
			ciram_a10 = ppu_addr[10];
		else
		begin
			case (regs[REG_MODE][2:1])
				// Vertical.
				2'd0: ciram_a10 = ppu_addr[10];
				// Horizontal.
				2'd1: ciram_a10 = ppu_addr[11];
				// First screen alone, the other three share.
				2'd2: ciram_a10 = |slot;
				default: ciram_a10 = 1'b0;
			endcase
		end
	end

	// Pattern tables below 0x2000, nametables above.
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce = ciram_ce;

	assign chr_oe = !ppu_oe;

	// Only CHR RAM takes writes.
	assign chr_we = cfg_chr_ram && !ppu_we && ciram_ce;

endmodule

`default_nettype wire

//--- tb/tb_map_sachen8259.sv
`default_nettype none

module tb_map_sachen8259
	import cart_bus_pkg::*, sachen_map_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 8;
	// Cycle budgets of the five tests.
	localparam int BUDGET_CYCLES = RESET_CYCLES + 20 + 400 + 600 + 300 + 120;
	localparam int WATCHDOG_NS = BUDGET_CYCLES * 4 + 200;

	logic                  m2;
	logic                  map_rst;
	logic [CPU_ADDR_W-1:0] cpu_addr;
	logic [7:0]            cpu_dat;
	logic                  cpu_rw;
	logic                  cpu_ce;
	logic [7:0]            map_idx;
	logic                  cfg_chr_ram;
	logic [PPU_ADDR_W-1:0] ppu_addr;
	logic                  ppu_oe;
	logic                  ppu_we;
	logic                  ss_act;
	logic                  ss_we;
	logic [7:0]            ss_addr;

	logic [PRG_ADDR_W-1:0] prg_addr;
	logic                  prg_oe;
	logic                  rom_ce;
	logic [CHR_ADDR_W-1:0] chr_addr;
	logic                  chr_oe;
	logic                  chr_we;
	logic                  chr_ce;
	logic                  ciram_a10;
	logic                  ciram_ce;
	logic [7:0]            ss_rdat;

	// Reference copy of the register file.
	logic [REG_W-1:0] m_regs [REG_COUNT];
	logic [2:0]       m_idx;

	logic [PRG_ADDR_W-1:0] exp_prg;
	logic [7:0]            exp_ss;
	logic [CHR_ADDR_W-1:0] exp_chr;
	logic                  exp_a10;
	logic                  exp_ce;
	logic                  exp_we;

	logic [7:0] map_list [4];

	int fail_cnt = 0;
	int test_cnt = 0;
	int test_fail_cnt = 0;

	map_sachen8259 map_sachen8259_i (
		.m2          (m2),
		.map_rst     (map_rst),
		.cpu_addr    (cpu_addr),
		.cpu_dat     (cpu_dat),
		.cpu_rw      (cpu_rw),
		.cpu_ce      (cpu_ce),
		.map_idx     (map_idx),
		.cfg_chr_ram (cfg_chr_ram),
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.ss_act      (ss_act),
		.ss_we       (ss_we),
		.ss_addr     (ss_addr),
		.prg_addr    (prg_addr),
		.prg_oe      (prg_oe),
		.rom_ce      (rom_ce),
		.chr_addr    (chr_addr),
		.chr_oe      (chr_oe),
		.chr_we      (chr_we),
		.chr_ce      (chr_ce),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce),
		.ss_rdat     (ss_rdat)
	);

	always #2 m2 = ~m2;

	// Register writes land on the falling edge.
	always @(negedge m2)
	begin
		if (map_rst)
		begin
			m_idx <= '0;
			for (int i = 0; i < REG_COUNT; i++)
				m_regs[i] <= '0;
		end
		else if (ss_act)
		begin
			if (ss_we && ss_addr < 8'd8)
				m_regs[ss_addr[2:0]] <= cpu_dat[2:0];
			if (ss_we && ss_addr == 8'd8)
				m_idx <= cpu_dat[2:0];
		end
		else if (cpu_ce && !cpu_rw && cpu_addr[14:8] == 7'h41)
		begin
			if (cpu_addr[0])
				m_regs[m_idx] <= cpu_dat[2:0];
			else
				m_idx <= cpu_dat[2:0];
		end
	end

	always_comb
	begin
		exp_prg = {m_regs[REG_PRG], cpu_addr[14:0]};
		if (ss_addr < 8'd8)
			exp_ss = {5'd0, m_regs[ss_addr[2:0]]};
		else if (ss_addr == 8'd8)
			exp_ss = {5'd0, m_idx};
		else if (ss_addr == 8'd127)
			exp_ss = map_idx;
		else
			exp_ss = 8'hFF;
	end

	// Expected CHR bank, built bit by bit.
	always_comb
	begin
		logic [1:0] slot_v;
		logic [2:0] sel_v;
		logic [8:0] bank_v;
		slot_v = ppu_addr[11:10];
		if (m_regs[REG_MODE][0])
			sel_v = m_regs[0];
		else
			sel_v = m_regs[{1'b0, ppu_addr[12:11]}];
		if (cfg_chr_ram)
			bank_v = {6'd0, ppu_addr[12:10]};
		else if (map_idx == 8'd137)
		begin
			if (ppu_addr[12])
				bank_v = {4'd0, 3'b111, slot_v};
			else
			begin
				bank_v = {6'd0, m_regs[{1'b0, slot_v}]};
				if (slot_v == 2'd1)
					bank_v[3] = m_regs[REG_HIGH][0];
				if (slot_v == 2'd2)
					bank_v[3] = m_regs[REG_HIGH][1];
				if (slot_v == 2'd3)
				begin
					bank_v[3] = m_regs[REG_HIGH][2];
					bank_v[4] = m_regs[REG_EXT][0];
				end
			end
		end
		else if (map_idx == 8'd138)
			bank_v = {2'd0, m_regs[REG_HIGH], sel_v, ppu_addr[10]};
		else if (map_idx == 8'd139)
			bank_v = {m_regs[REG_HIGH], sel_v, ppu_addr[12:10]};
		else
			bank_v = {1'b0, m_regs[REG_HIGH], sel_v, ppu_addr[11:10]};
		exp_chr = {bank_v, ppu_addr[9:0]};
	end

	always_comb
	begin
		if (m_regs[REG_MODE][0] || m_regs[REG_MODE][2:1] == 2'd0)
			exp_a10 = ppu_addr[10];
		else if (m_regs[REG_MODE][2:1] == 2'd1)
			exp_a10 = ppu_addr[11];
		else if (m_regs[REG_MODE][2:1] == 2'd2)
			exp_a10 = ppu_addr[11:10] != 2'b00;
		else
			exp_a10 = 1'b0;
		exp_ce = !ppu_addr[13];
		exp_we = cfg_chr_ram && !ppu_we && !ppu_addr[13];
	end

	a_prg: assert property (@(posedge m2) disable iff (map_rst) prg_addr == exp_prg)
	else
	begin
		$display("error %0t: prg_addr %h, expected %h", $time, $sampled(prg_addr),
			$sampled(exp_prg));
		fail_cnt++;
	end

	a_prg_ctl: assert property (@(posedge m2) disable iff (map_rst)
		prg_oe == cpu_rw && rom_ce == !cpu_ce)
	else
	begin
		$display("error %0t: prg_oe or rom_ce does not follow the CPU bus", $time);
		fail_cnt++;
	end

	a_ss: assert property (@(posedge m2) disable iff (map_rst) ss_rdat == exp_ss)
	else
	begin
		$display("error %0t: ss_rdat %h at address %0d, expected %h", $time,
			$sampled(ss_rdat), $sampled(ss_addr), $sampled(exp_ss));
		fail_cnt++;
	end

	a_chr: assert property (@(posedge m2) disable iff (map_rst) chr_addr == exp_chr)
	else
	begin
		$display("error %0t: chr_addr %h for ppu_addr %h, expected %h", $time,
			$sampled(chr_addr), $sampled(ppu_addr), $sampled(exp_chr));
		fail_cnt++;
	end

	a_chr_ram: assert property (@(posedge m2) disable iff (map_rst)
		!cfg_chr_ram || chr_addr == {6'd0, ppu_addr[12:0]})
	else
	begin
		$display("error %0t: chr_addr %h is not the CHR RAM address", $time,
			$sampled(chr_addr));
		fail_cnt++;
	end

	a_a10: assert property (@(posedge m2) disable iff (map_rst) ciram_a10 == exp_a10)
	else
	begin
		$display("error %0t: ciram_a10 %b, expected %b", $time, $sampled(ciram_a10),
			$sampled(exp_a10));
		fail_cnt++;
	end

	a_strobes: assert property (@(posedge m2) disable iff (map_rst)
		ciram_ce == exp_ce && chr_ce == exp_ce && chr_oe == !ppu_oe && chr_we == exp_we)
	else
	begin
		$display("error %0t: CHR or CIRAM strobe does not match the PPU bus", $time);
		fail_cnt++;
	end

	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] dat,
		input logic rw, input logic ce);
		@(posedge m2);
		cpu_addr <= addr;
		cpu_dat <= dat;
		cpu_rw <= rw;
		cpu_ce <= ce;
	endtask

	// Index write, then data write.
	task automatic write_reg(input int idx, input logic [2:0] val);
		bus_cycle(16'h4100, 8'(idx), 1'b0, 1'b1);
		bus_cycle(16'h4101, {5'd0, val}, 1'b0, 1'b1);
	endtask

	task automatic ppu_cycle(input logic [13:0] pa);
		@(posedge m2);
		ppu_addr <= pa;
		ppu_oe <= 1'($urandom());
		ppu_we <= 1'($urandom());
		cpu_addr <= 16'($urandom());
		cpu_rw <= 1'b1;
		cpu_ce <= 1'b0;
	endtask

	task automatic ss_read(input logic [7:0] a);
		@(posedge m2);
		ss_we <= 1'b0;
		ss_addr <= a;
		cpu_rw <= 1'b1;
		cpu_ce <= 1'b0;
		map_idx <= 8'($urandom());
	endtask

	task automatic finish_test(input string name, input int fails_before);
		int new_fails;
		// Let the last driven cycle be checked.
		@(posedge m2);
		#1;
		new_fails = fail_cnt - fails_before;
		test_cnt++;
		if (new_fails != 0)
			test_fail_cnt++;
		$display("test %s: done, %0d assertion failures", name, new_fails);
	endtask

	task automatic check_reset_state();
		int start;
		start = fail_cnt;
		for (int a = 0; a <= 8; a++)
		begin
			@(posedge m2);
			ss_addr <= 8'(a);
		end
		finish_test("reset state", start);
	endtask

	task automatic run_cpu_writes();
		int start;
		int kind;
		logic [6:0] page;
		logic [15:0] addr;
		start = fail_cnt;
		for (int i = 0; i < 300; i++)
		begin
			// 0 index, 1 data, 2 off page, 3 read, 4 no ce, 5 any read.
			kind = int'($urandom_range(5));
			page = (kind == 2 || kind == 5) ? 7'($urandom()) : REG_PAGE;
			if (kind == 2 && page == REG_PAGE)
				page = page ^ 7'h01;
			addr = {1'($urandom()), page, 7'($urandom()), 1'($urandom())};
			if (kind == 0)
				addr[0] = 1'b0;
			if (kind == 1)
				addr[0] = 1'b1;
			bus_cycle(addr, 8'($urandom()), kind == 3 || kind == 5, kind != 4);
			ss_addr <= 8'($urandom_range(8));
			ppu_addr <= 14'($urandom());
		end
		finish_test("cpu register writes", start);
	endtask

	task automatic run_chr_banking();
		int start;
		start = fail_cnt;
		for (int mi = 0; mi < 4; mi++)
		begin
			for (int sm = 0; sm < 2; sm++)
			begin
				@(posedge m2);
				map_idx <= map_list[mi];
				cfg_chr_ram <= 1'b0;
				for (int r = 0; r < REG_MODE; r++)
					write_reg(r, 3'($urandom()));
				write_reg(REG_MODE, {2'($urandom()), 1'(sm)});
				repeat (40)
					ppu_cycle(14'($urandom()));
			end
		end
		finish_test("chr banking", start);
	endtask

	task automatic run_mirroring();
		int start;
		logic [13:0] pa;
		start = fail_cnt;
		for (int ram = 0; ram < 2; ram++)
		begin
			// Modes 0 to 3, then simple mode.
			for (int m = 0; m < 5; m++)
			begin
				@(posedge m2);
				cfg_chr_ram <= 1'(ram);
				map_idx <= map_list[$urandom_range(3)];
				write_reg(REG_MODE, (m == 4) ? {2'($urandom()), 1'b1} : {2'(m), 1'b0});
				for (int i = 0; i < 16; i++)
				begin
					pa = 14'($urandom());
					pa[11:10] = 2'(i);
					ppu_cycle(pa);
				end
			end
		end
		@(posedge m2);
		cfg_chr_ram <= 1'b0;
		finish_test("mirroring and strobes", start);
	endtask

	task automatic run_save_state();
		int start;
		logic [7:0] other;
		start = fail_cnt;
		// CPU writes ride along and have to be dropped.
		for (int a = 0; a <= 8; a++)
		begin
			@(posedge m2);
			ss_act <= 1'b1;
			ss_we <= 1'b1;
			ss_addr <= 8'(a);
			cpu_addr <= {8'h41, 7'($urandom()), 1'(a)};
			cpu_dat <= 8'($urandom());
			cpu_rw <= 1'b0;
			cpu_ce <= 1'b1;
		end
		// No save-state target here, so a CPU write that gets through shows up.
		@(posedge m2);
		ss_addr <= 8'd20;
		cpu_addr <= 16'h4100;
		cpu_dat <= {5'd0, ~m_idx};
		@(posedge m2);
		cpu_addr <= 16'h4101;
		cpu_dat <= {5'd0, ~m_regs[m_idx]};
		for (int a = 0; a <= 8; a++)
			ss_read(8'(a));
		ss_read(SS_IDX_ADDR);
		repeat (4)
		begin
			other = 8'($urandom_range(255, 9));
			if (other == SS_IDX_ADDR)
				other = 8'd200;
			ss_read(other);
		end
		// Reset wins over a save-state write.
		@(posedge m2);
		map_rst <= 1'b1;
		ss_we <= 1'b1;
		ss_addr <= 8'd2;
		cpu_dat <= 8'h07;
		repeat (2) @(posedge m2);
		map_rst <= 1'b0;
		ss_we <= 1'b0;
		for (int a = 0; a <= 8; a++)
			ss_read(8'(a));
		@(posedge m2);
		ss_act <= 1'b0;
		finish_test("save state", start);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog: the tests did not finish within %0d ns.", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32));
		m2 = 1'b0;
		map_rst = 1'b1;
		cpu_addr = '0;
		cpu_dat = '0;
		cpu_rw = 1'b1;
		cpu_ce = 1'b0;
		map_idx = MAP_137;
		cfg_chr_ram = 1'b0;
		ppu_addr = '0;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = '0;
		map_list = '{MAP_137, MAP_138, MAP_139, MAP_141};
		repeat (RESET_CYCLES) @(posedge m2);
		map_rst <= 1'b0;
		check_reset_state();
		run_cpu_writes();
		run_chr_banking();
		run_mirroring();
		run_save_state();
		$display("tests run %0d, tests failed %0d, assertion failures %0d", test_cnt,
			test_fail_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
